// File: tb.f
hw/axi_pkg.sv
hw/bus_arbiter.sv
hw/mem_slave.sv
hw/clint_slave.sv
hw/soc_bus_top.sv
testbench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the failure line
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_top -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

// File: testbench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top import axi_pkg::*; ();

  localparam int     TIMEOUT    = 100;
  localparam burst_t BURST_INCR = 2'b01;

  logic clock = 1'b0;
  logic reset;

  logic   ifu_arvalid_i;
  addr_t  ifu_araddr_i;
  id_t    ifu_arid_i;
  len_t   ifu_arlen_i;
  size_t  ifu_arsize_i;
  burst_t ifu_arburst_i;
  logic   ifu_arready_o;
  logic   ifu_rvalid_o;
  data_t  ifu_rdata_o;
  resp_t  ifu_rresp_o;
  id_t    ifu_rid_o;
  logic   ifu_rlast_o;
  logic   ifu_rready_i;

  logic   exu_arvalid_i;
  addr_t  exu_araddr_i;
  id_t    exu_arid_i;
  len_t   exu_arlen_i;
  size_t  exu_arsize_i;
  burst_t exu_arburst_i;
  logic   exu_arready_o;
  logic   exu_rvalid_o;
  data_t  exu_rdata_o;
  resp_t  exu_rresp_o;
  id_t    exu_rid_o;
  logic   exu_rlast_o;
  logic   exu_rready_i;
  logic   exu_awvalid_i;
  addr_t  exu_awaddr_i;
  id_t    exu_awid_i;
  len_t   exu_awlen_i;
  size_t  exu_awsize_i;
  burst_t exu_awburst_i;
  logic   exu_awready_o;
  logic   exu_wvalid_i;
  data_t  exu_wdata_i;
  strb_t  exu_wstrb_i;
  logic   exu_wlast_i;
  logic   exu_wready_o;
  logic   exu_bvalid_o;
  resp_t  exu_bresp_o;
  id_t    exu_bid_o;
  logic   exu_bready_i;

  // reference model of the four words at 0x100 and the captured read beats.
  data_t exp_mem [4];
  data_t wr_data [4];
  strb_t wr_strb [4];
  data_t rd_data [16];
  resp_t rd_resp [16];
  id_t   rd_id   [16];
  logic  rd_last [16];
  int    rd_count;

  int value_errors = 0;
  int other_errors = 0;
  logic [15:0] lfsr_q = 16'd30342;

  soc_bus_top #(.MEM_WORDS(256)) dut0 (.*);

  initial begin
    forever #4 clock = ~clock;
  end

  // ##################################################
  // random bits and compare tasks.
  // ##################################################
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit taken.
  function automatic data_t take_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      value_errors++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    other_errors++;
  endtask

  // ##################################################
  // bus driving helpers.
  // ##################################################
  task automatic init_inputs();
    reset = 1'b1;
    ifu_arvalid_i = 1'b0;
    ifu_araddr_i  = '0;
    ifu_arid_i    = '0;
    ifu_arlen_i   = '0;
    ifu_arsize_i  = '0;
    ifu_arburst_i = '0;
    ifu_rready_i  = 1'b0;
    exu_arvalid_i = 1'b0;
    exu_araddr_i  = '0;
    exu_arid_i    = '0;
    exu_arlen_i   = '0;
    exu_arsize_i  = '0;
    exu_arburst_i = '0;
    exu_rready_i  = 1'b0;
    exu_awvalid_i = 1'b0;
    exu_awaddr_i  = '0;
    exu_awid_i    = '0;
    exu_awlen_i   = '0;
    exu_awsize_i  = '0;
    exu_awburst_i = '0;
    exu_wvalid_i  = 1'b0;
    exu_wdata_i   = '0;
    exu_wstrb_i   = '0;
    exu_wlast_i   = 1'b0;
    exu_bready_i  = 1'b0;
  endtask

  task automatic drive_ar(input bit ifu, input logic valid, input addr_t addr,
                          input id_t id, input len_t len);
    if (ifu) begin
      ifu_arvalid_i = valid;
      ifu_araddr_i  = addr;
      ifu_arid_i    = id;
      ifu_arlen_i   = len;
      ifu_arsize_i  = 3'd2;
      ifu_arburst_i = BURST_INCR;
    end else begin
      exu_arvalid_i = valid;
      exu_araddr_i  = addr;
      exu_arid_i    = id;
      exu_arlen_i   = len;
      exu_arsize_i  = 3'd2;
      exu_arburst_i = BURST_INCR;
    end
  endtask

  function automatic logic ar_ready(input bit ifu);
    return ifu ? ifu_arready_o : exu_arready_o;
  endfunction

  task automatic drive_rready(input bit ifu, input logic rdy);
    if (ifu) ifu_rready_i = rdy;
    else exu_rready_i = rdy;
  endtask

  task automatic sample_r(input bit ifu, output logic v, output data_t d, output resp_t r,
                          output id_t id, output logic last);
    if (ifu) begin
      v    = ifu_rvalid_o;
      d    = ifu_rdata_o;
      r    = ifu_rresp_o;
      id   = ifu_rid_o;
      last = ifu_rlast_o;
    end else begin
      v    = exu_rvalid_o;
      d    = exu_rdata_o;
      r    = exu_rresp_o;
      id   = exu_rid_o;
      last = exu_rlast_o;
    end
  endtask

  // inputs change on the falling edge and outputs are sampled 1 ns later.
  task automatic bus_read(input bit ifu, input addr_t addr, input id_t id, input int beats,
                          input bit throttle);
    int    t;
    logic  v;
    data_t d;
    resp_t r;
    id_t   rid;
    logic  last;
    logic  rdy;
    data_t rnd;
    bit    done;
    rd_count = 0;
    done = 1'b0;
    @(negedge clock);
    drive_ar(ifu, 1'b1, addr, id, len_t'(beats - 1));
    #1;
    t = 0;
    while (!ar_ready(ifu) && t < TIMEOUT) begin
      @(negedge clock);
      #1;
      t++;
    end
    if (!ar_ready(ifu)) report_problem(ifu ? "no ifu_arready_o" : "no exu_arready_o");
    @(negedge clock);
    drive_ar(ifu, 1'b0, '0, '0, '0);
    t = 0;
    while (!done && t < TIMEOUT) begin
      rnd = take_bits(1);
      rdy = throttle ? rnd[0] : 1'b1;
      drive_rready(ifu, rdy);
      #1;
      sample_r(ifu, v, d, r, rid, last);
      if (ifu) check_bit("exu_rvalid_o", 1'b0, exu_rvalid_o);
      if (v && rdy) begin
        if (rd_count < 16) begin
          rd_data[rd_count] = d;
          rd_resp[rd_count] = r;
          rd_id[rd_count]   = rid;
          rd_last[rd_count] = last;
        end
        rd_count++;
        done = last;
      end
      @(negedge clock);
      t++;
    end
    drive_rready(ifu, 1'b0);
    if (!done) report_problem("read burst did not finish with rlast");
  endtask

  task automatic exu_write(input addr_t addr, input id_t id, input int beats);
    int t;
    @(negedge clock);
    exu_awvalid_i = 1'b1;
    exu_awaddr_i  = addr;
    exu_awid_i    = id;
    exu_awlen_i   = len_t'(beats - 1);
    exu_awsize_i  = 3'd2;
    exu_awburst_i = BURST_INCR;
    #1;
    t = 0;
    while (!exu_awready_o && t < TIMEOUT) begin
      @(negedge clock);
      #1;
      t++;
    end
    if (!exu_awready_o) report_problem("no exu_awready_o");
    @(negedge clock);
    exu_awvalid_i = 1'b0;
    for (int i = 0; i < beats; i++) begin
      exu_wvalid_i = 1'b1;
      exu_wdata_i  = wr_data[i];
      exu_wstrb_i  = wr_strb[i];
      exu_wlast_i  = (i == beats - 1);
      #1;
      t = 0;
      while (!exu_wready_o && t < TIMEOUT) begin
        @(negedge clock);
        #1;
        t++;
      end
      if (!exu_wready_o) report_problem("no exu_wready_o during write burst");
      @(negedge clock);
    end
    exu_wvalid_i = 1'b0;
    exu_wlast_i  = 1'b0;
    exu_bready_i = 1'b1;
    #1;
    t = 0;
    while (!exu_bvalid_o && t < TIMEOUT) begin
      @(negedge clock);
      #1;
      t++;
    end
    if (!exu_bvalid_o) begin
      report_problem("no write response on exu_bvalid_o");
    end else begin
      check_resp("exu_bresp_o", RESP_OKAY, exu_bresp_o);
      check_id("exu_bid_o", id, exu_bid_o);
    end
    @(negedge clock);
    exu_bready_i = 1'b0;
  endtask

  // byte-lane merge of a strobed write into the model.
  function automatic data_t merge_bytes(input data_t old, input data_t nw, input strb_t s);
    data_t m;
    m = old;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) m[8*b +: 8] = nw[8*b +: 8];
    end
    return m;
  endfunction

  task automatic check_read_beats(input string port, input id_t id, input int beats);
    if (rd_count != beats) begin
      report_problem($sformatf("%s read returned %0d beats, %0d requested",
                               port, rd_count, beats));
    end
    for (int i = 0; i < rd_count && i < beats; i++) begin
      check_data({port, "_rdata_o"}, exp_mem[i], rd_data[i]);
      check_resp({port, "_rresp_o"}, RESP_OKAY, rd_resp[i]);
      check_id({port, "_rid_o"}, id, rd_id[i]);
      check_bit({port, "_rlast_o"}, i == beats - 1, rd_last[i]);
    end
  endtask

  // ##################################################
  // directed tests.
  // ##################################################
  task automatic expect_outputs_low();
    check_bit("ifu_arready_o", 1'b0, ifu_arready_o);
    check_bit("ifu_rvalid_o", 1'b0, ifu_rvalid_o);
    check_bit("exu_arready_o", 1'b0, exu_arready_o);
    check_bit("exu_rvalid_o", 1'b0, exu_rvalid_o);
    check_bit("exu_awready_o", 1'b0, exu_awready_o);
    check_bit("exu_wready_o", 1'b0, exu_wready_o);
    check_bit("exu_bvalid_o", 1'b0, exu_bvalid_o);
  endtask

  // reset covers the first two rising edges and drops on the second falling edge.
  task automatic reset_outputs_low();
    @(negedge clock);
    #1;
    expect_outputs_low();
    @(negedge clock);
    reset = 1'b0;
    #1;
    expect_outputs_low();
    @(negedge clock);
    #1;
    expect_outputs_low();
  endtask

  task automatic write_and_read_back();
    // full-word fill first so the partial beat merges into known data.
    for (int i = 0; i < 4; i++) begin
      wr_data[i] = take_bits(32);
      wr_strb[i] = 4'hF;
      exp_mem[i] = wr_data[i];
    end
    exu_write(32'h100, 4'h3, 4);
    for (int i = 0; i < 4; i++) begin
      wr_data[i] = take_bits(32);
      wr_strb[i] = (i == 1) ? 4'b0011 : 4'hF;
      exp_mem[i] = merge_bytes(exp_mem[i], wr_data[i], wr_strb[i]);
    end
    exu_write(32'h100, 4'h5, 4);
    bus_read(1'b0, 32'h100, 4'h6, 4, 1'b0);
    check_read_beats("exu", 4'h6, 4);
  endtask

  task automatic ifu_throttled_read();
    bus_read(1'b1, 32'h100, 4'h2, 4, 1'b1);
    check_read_beats("ifu", 4'h2, 4);
  endtask

  task automatic clint_mtime_read();
    addr_t lo_addr;
    data_t first;
    data_t second;
    lo_addr = CLINT_BASE | addr_t'(MTIME_LO_OFS);
    bus_read(1'b0, lo_addr, 4'h9, 1, 1'b0);
    first = rd_data[0];
    check_resp("exu_rresp_o", RESP_OKAY, rd_resp[0]);
    check_id("exu_rid_o", 4'h9, rd_id[0]);
    check_bit("exu_rlast_o", 1'b1, rd_last[0]);
    bus_read(1'b0, lo_addr, 4'hA, 1, 1'b0);
    second = rd_data[0];
    check_resp("exu_rresp_o", RESP_OKAY, rd_resp[0]);
    check_bit("mtime increase between reads", 1'b1, second > first);
    // offset 0 holds no register.
    bus_read(1'b0, CLINT_BASE, 4'hB, 1, 1'b0);
    check_resp("exu_rresp_o", RESP_SLVERR, rd_resp[0]);
    bus_read(1'b0, 32'h100, 4'hC, 1, 1'b0);
    check_read_beats("exu", 4'hC, 1);
  endtask

  task automatic read_priority();
    int cyc;
    int exu_ar_cyc;
    int ifu_ar_cyc;
    int exu_n;
    int ifu_n;
    bit exu_drop;
    bit ifu_drop;
    exu_ar_cyc = -1;
    ifu_ar_cyc = -1;
    exu_n = 0;
    ifu_n = 0;
    exu_drop = 1'b0;
    ifu_drop = 1'b0;
    @(negedge clock);
    drive_ar(1'b0, 1'b1, 32'h100, 4'h7, 8'd3);
    drive_ar(1'b1, 1'b1, 32'h100, 4'h8, 8'd3);
    exu_rready_i = 1'b1;
    ifu_rready_i = 1'b1;
    for (cyc = 0; cyc < TIMEOUT && ifu_n < 4; cyc++) begin
      if (cyc > 0) @(negedge clock);
      if (exu_drop) drive_ar(1'b0, 1'b0, '0, '0, '0);
      if (ifu_drop) drive_ar(1'b1, 1'b0, '0, '0, '0);
      exu_drop = 1'b0;
      ifu_drop = 1'b0;
      #1;
      if (exu_arvalid_i && exu_arready_o) begin
        exu_ar_cyc = cyc;
        exu_drop = 1'b1;
      end
      if (ifu_arvalid_i && ifu_arready_o) begin
        ifu_ar_cyc = cyc;
        ifu_drop = 1'b1;
      end
      if (exu_rvalid_o) begin
        check_data("exu_rdata_o", exp_mem[exu_n % 4], exu_rdata_o);
        exu_n++;
      end
      if (ifu_rvalid_o) begin
        check_bit("exu burst complete before ifu beat", 1'b1, exu_n == 4);
        check_data("ifu_rdata_o", exp_mem[ifu_n % 4], ifu_rdata_o);
        ifu_n++;
      end
    end
    @(negedge clock);
    exu_rready_i = 1'b0;
    ifu_rready_i = 1'b0;
    drive_ar(1'b0, 1'b0, '0, '0, '0);
    drive_ar(1'b1, 1'b0, '0, '0, '0);
    check_bit("exu_arready_o one cycle after valid", 1'b1, exu_ar_cyc >= 1);
    check_bit("exu_arready_o before ifu_arready_o", 1'b1,
              exu_ar_cyc >= 0 && exu_ar_cyc < ifu_ar_cyc);
    if (exu_n != 4) report_problem($sformatf("exu received %0d beats, expected 4", exu_n));
    if (ifu_n != 4) report_problem($sformatf("ifu received %0d beats, expected 4", ifu_n));
  endtask

  initial begin
    init_inputs();
    reset_outputs_low();
    write_and_read_back();
    ifu_throttled_read();
    clint_mtime_read();
    read_priority();
    repeat (2) @(negedge clock);
    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hw/soc_bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_top import axi_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  wire    clock,
  input  wire    reset,
  // IFU read master.
  input  wire    ifu_arvalid_i,
  input  addr_t  ifu_araddr_i,
  input  id_t    ifu_arid_i,
  input  len_t   ifu_arlen_i,
  input  size_t  ifu_arsize_i,
  input  burst_t ifu_arburst_i,
  output logic   ifu_arready_o,
  output logic   ifu_rvalid_o,
  output data_t  ifu_rdata_o,
  output resp_t  ifu_rresp_o,
  output id_t    ifu_rid_o,
  output logic   ifu_rlast_o,
  input  wire    ifu_rready_i,
  // EXU master.
  input  wire    exu_arvalid_i,
  input  addr_t  exu_araddr_i,
  input  id_t    exu_arid_i,
  input  len_t   exu_arlen_i,
  input  size_t  exu_arsize_i,
  input  burst_t exu_arburst_i,
  output logic   exu_arready_o,
  output logic   exu_rvalid_o,
  output data_t  exu_rdata_o,
  output resp_t  exu_rresp_o,
  output id_t    exu_rid_o,
  output logic   exu_rlast_o,
  input  wire    exu_rready_i,
  input  wire    exu_awvalid_i,
  input  addr_t  exu_awaddr_i,
  input  id_t    exu_awid_i,
  input  len_t   exu_awlen_i,
  input  size_t  exu_awsize_i,
  input  burst_t exu_awburst_i,
  output logic   exu_awready_o,
  input  wire    exu_wvalid_i,
  input  data_t  exu_wdata_i,
  input  strb_t  exu_wstrb_i,
  input  wire    exu_wlast_i,
  output logic   exu_wready_o,
  output logic   exu_bvalid_o,
  output resp_t  exu_bresp_o,
  output id_t    exu_bid_o,
  input  wire    exu_bready_i
);

  // ##################################################
  // arbiter to memory slave.
  // ##################################################
  logic   m_arvalid, m_arready, m_rvalid, m_rlast, m_rready;
  addr_t  m_araddr, m_awaddr;
  id_t    m_arid, m_rid, m_awid, m_bid;
  len_t   m_arlen, m_awlen;
  size_t  m_arsize, m_awsize;
  burst_t m_arburst, m_awburst;
  data_t  m_rdata, m_wdata;
  resp_t  m_rresp, m_bresp;
  logic   m_awvalid, m_awready, m_wvalid, m_wlast, m_wready, m_bvalid, m_bready;
  strb_t  m_wstrb;

  // arbiter to CLINT slave.
  logic   c_arvalid, c_arready, c_rvalid, c_rlast, c_rready;
  addr_t  c_araddr;
  id_t    c_arid, c_rid;
  data_t  c_rdata;
  resp_t  c_rresp;

  // master ports connect by name.
  bus_arbiter arb0 (
    .*,
    .mem_arvalid_o(m_arvalid), .mem_araddr_o(m_araddr), .mem_arid_o(m_arid),
    .mem_arlen_o(m_arlen), .mem_arsize_o(m_arsize), .mem_arburst_o(m_arburst),
    .mem_arready_i(m_arready), .mem_rvalid_i(m_rvalid), .mem_rdata_i(m_rdata),
    .mem_rresp_i(m_rresp), .mem_rid_i(m_rid), .mem_rlast_i(m_rlast),
    .mem_rready_o(m_rready), .mem_awvalid_o(m_awvalid), .mem_awaddr_o(m_awaddr),
    .mem_awid_o(m_awid), .mem_awlen_o(m_awlen), .mem_awsize_o(m_awsize),
    .mem_awburst_o(m_awburst), .mem_awready_i(m_awready), .mem_wvalid_o(m_wvalid),
    .mem_wdata_o(m_wdata), .mem_wstrb_o(m_wstrb), .mem_wlast_o(m_wlast),
    .mem_wready_i(m_wready), .mem_bvalid_i(m_bvalid), .mem_bresp_i(m_bresp),
    .mem_bid_i(m_bid), .mem_bready_o(m_bready),
    .clint_arvalid_o(c_arvalid), .clint_araddr_o(c_araddr), .clint_arid_o(c_arid),
    .clint_arready_i(c_arready), .clint_rvalid_i(c_rvalid), .clint_rdata_i(c_rdata),
    .clint_rresp_i(c_rresp), .clint_rid_i(c_rid), .clint_rlast_i(c_rlast),
    .clint_rready_o(c_rready)
  );

  mem_slave #(.MEM_WORDS(MEM_WORDS)) mem0 (
    .clock(clock), .reset(reset),
    .s_arvalid_i(m_arvalid), .s_araddr_i(m_araddr), .s_arid_i(m_arid),
    .s_arlen_i(m_arlen), .s_arsize_i(m_arsize), .s_arburst_i(m_arburst),
    .s_arready_o(m_arready), .s_rvalid_o(m_rvalid), .s_rdata_o(m_rdata),
    .s_rresp_o(m_rresp), .s_rid_o(m_rid), .s_rlast_o(m_rlast), .s_rready_i(m_rready),
    .s_awvalid_i(m_awvalid), .s_awaddr_i(m_awaddr), .s_awid_i(m_awid),
    .s_awlen_i(m_awlen), .s_awsize_i(m_awsize), .s_awburst_i(m_awburst),
    .s_awready_o(m_awready), .s_wvalid_i(m_wvalid), .s_wdata_i(m_wdata),
    .s_wstrb_i(m_wstrb), .s_wlast_i(m_wlast), .s_wready_o(m_wready),
    .s_bvalid_o(m_bvalid), .s_bresp_o(m_bresp), .s_bid_o(m_bid), .s_bready_i(m_bready)
  );

  clint_slave clint0 (
    .clock(clock), .reset(reset),
    .c_arvalid_i(c_arvalid), .c_araddr_i(c_araddr), .c_arid_i(c_arid),
    .c_arready_o(c_arready), .c_rvalid_o(c_rvalid), .c_rdata_o(c_rdata),
    .c_rresp_o(c_rresp), .c_rid_o(c_rid), .c_rlast_o(c_rlast), .c_rready_i(c_rready)
  );

endmodule

`default_nettype wire

// File: hw/clint_slave.sv
`timescale 1ns/1ps
`default_nettype none

module clint_slave import axi_pkg::*; (
  input  wire   clock,
  input  wire   reset,
  input  wire   c_arvalid_i,
  input  addr_t c_araddr_i,
  input  id_t   c_arid_i,
  output logic  c_arready_o,
  output logic  c_rvalid_o,
  output data_t c_rdata_o,
  output resp_t c_rresp_o,
  output id_t   c_rid_o,
  output logic  c_rlast_o,
  input  wire   c_rready_i
);

  logic [63:0] mtime;
  logic        busy;
  logic [15:0] ofs_q;
  logic [63:0] snap_q;
  id_t         id_q;

  // free running machine timer.
  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // ##################################################
  // single-beat read machine.
  // ##################################################
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (c_arvalid_i && c_arready_o) begin
      busy <= 1'b1;
    end else if (c_rready_i) begin
      busy <= 1'b0;
    end
  end

  // offset, id and timer value as seen at the AR handshake.
  always_ff @(posedge clock) begin
    if (c_arvalid_i && c_arready_o) begin
      ofs_q  <= c_araddr_i[15:0];
      snap_q <= mtime;
      id_q   <= c_arid_i;
    end
  end

  assign c_arready_o = !busy;
  assign c_rvalid_o  = busy;
  assign c_rlast_o   = busy;
  assign c_rid_o     = id_q;

  always_comb begin
    c_rdata_o = '0;
    c_rresp_o = RESP_SLVERR;
    if (ofs_q == MTIME_LO_OFS) begin
      c_rdata_o = snap_q[31:0];
      c_rresp_o = RESP_OKAY;
    end else if (ofs_q == MTIME_HI_OFS) begin
      c_rdata_o = snap_q[63:32];
      c_rresp_o = RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_slave.sv
`timescale 1ns/1ps
`default_nettype none

module mem_slave import axi_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  wire    clock,
  input  wire    reset,
  input  wire    s_arvalid_i,
  input  addr_t  s_araddr_i,
  input  id_t    s_arid_i,
  input  len_t   s_arlen_i,
  input  size_t  s_arsize_i,
  input  burst_t s_arburst_i,
  output logic   s_arready_o,
  output logic   s_rvalid_o,
  output data_t  s_rdata_o,
  output resp_t  s_rresp_o,
  output id_t    s_rid_o,
  output logic   s_rlast_o,
  input  wire    s_rready_i,
  input  wire    s_awvalid_i,
  input  addr_t  s_awaddr_i,
  input  id_t    s_awid_i,
  input  len_t   s_awlen_i,
  input  size_t  s_awsize_i,
  input  burst_t s_awburst_i,
  output logic   s_awready_o,
  input  wire    s_wvalid_i,
  input  data_t  s_wdata_i,
  input  strb_t  s_wstrb_i,
  input  wire    s_wlast_i,
  output logic   s_wready_o,
  output logic   s_bvalid_o,
  output resp_t  s_bresp_o,
  output id_t    s_bid_o,
  input  wire    s_bready_i
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam burst_t BURST_FIXED = 2'b00;

  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_t;

  data_t     mem [MEM_WORDS];
  logic      rd_busy;
  addr_t     rd_addr;
  addr_t     rd_step;
  len_t      rd_cnt;
  id_t       rd_id;
  wr_state_t wr_state;
  addr_t     wr_addr;
  addr_t     wr_step;
  id_t       wr_id;

  // word index of a byte address, wrapped to the memory depth.
  function automatic logic [IDX_W-1:0] word_idx(input addr_t a);
    addr_t w;
    w = (a >> 2) % MEM_WORDS;
    return w[IDX_W-1:0];
  endfunction

  // address advance per beat; zero for FIXED bursts.
  function automatic addr_t beat_step(input burst_t b, input size_t s);
    return (b == BURST_FIXED) ? '0 : (addr_t'(1) << s);
  endfunction

  // ##################################################
  // read channel.
  // ##################################################
  assign s_arready_o = !rd_busy;
  assign s_rvalid_o  = rd_busy;
  assign s_rdata_o   = mem[word_idx(rd_addr)];
  assign s_rresp_o   = RESP_OKAY;
  assign s_rid_o     = rd_id;
  assign s_rlast_o   = rd_busy && (rd_cnt == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_busy <= 1'b0;
    end else if (s_arvalid_i && s_arready_o) begin
      rd_busy <= 1'b1;
    end else if (s_rvalid_o && s_rready_i && s_rlast_o) begin
      rd_busy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (s_arvalid_i && s_arready_o) begin
      rd_addr <= s_araddr_i;
      rd_step <= beat_step(s_arburst_i, s_arsize_i);
      rd_cnt  <= s_arlen_i;
      rd_id   <= s_arid_i;
    end else if (s_rvalid_o && s_rready_i) begin
      rd_addr <= rd_addr + rd_step;
      rd_cnt  <= rd_cnt - 1'b1;
    end
  end

  // ##################################################
  // write channel.
  // ##################################################
  assign s_awready_o = (wr_state == W_IDLE);
  assign s_wready_o  = (wr_state == W_DATA);
  assign s_bvalid_o  = (wr_state == W_RESP);
  assign s_bresp_o   = RESP_OKAY;
  assign s_bid_o     = wr_id;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_state <= W_IDLE;
    end else begin
      case (wr_state)
        W_IDLE: if (s_awvalid_i) wr_state <= W_DATA;
        W_DATA: if (s_wvalid_i && s_wlast_i) wr_state <= W_RESP;
        W_RESP: if (s_bready_i) wr_state <= W_IDLE;
        default: wr_state <= W_IDLE;
      endcase
    end
  end

  // only strobed byte lanes are written.
  always_ff @(posedge clock) begin
    if (s_awvalid_i && s_awready_o) begin
      wr_addr <= s_awaddr_i;
      wr_step <= beat_step(s_awburst_i, s_awsize_i);
      wr_id   <= s_awid_i;
    end else if (s_wvalid_i && s_wready_o) begin
      wr_addr <= wr_addr + wr_step;
      for (int b = 0; b < 4; b++) begin
        if (s_wstrb_i[b]) mem[word_idx(wr_addr)][8*b +: 8] <= s_wdata_i[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import axi_pkg::*; (
  input  wire    clock,
  input  wire    reset,

  // IFU read master.
  input  wire    ifu_arvalid_i,
  input  addr_t  ifu_araddr_i,
  input  id_t    ifu_arid_i,
  input  len_t   ifu_arlen_i,
  input  size_t  ifu_arsize_i,
  input  burst_t ifu_arburst_i,
  output logic   ifu_arready_o,
  output logic   ifu_rvalid_o,
  output data_t  ifu_rdata_o,
  output resp_t  ifu_rresp_o,
  output id_t    ifu_rid_o,
  output logic   ifu_rlast_o,
  input  wire    ifu_rready_i,

  // EXU read and write master.
  input  wire    exu_arvalid_i,
  input  addr_t  exu_araddr_i,
  input  id_t    exu_arid_i,
  input  len_t   exu_arlen_i,
  input  size_t  exu_arsize_i,
  input  burst_t exu_arburst_i,
  output logic   exu_arready_o,
  output logic   exu_rvalid_o,
  output data_t  exu_rdata_o,
  output resp_t  exu_rresp_o,
  output id_t    exu_rid_o,
  output logic   exu_rlast_o,
  input  wire    exu_rready_i,
  input  wire    exu_awvalid_i,
  input  addr_t  exu_awaddr_i,
  input  id_t    exu_awid_i,
  input  len_t   exu_awlen_i,
  input  size_t  exu_awsize_i,
  input  burst_t exu_awburst_i,
  output logic   exu_awready_o,
  input  wire    exu_wvalid_i,
  input  data_t  exu_wdata_i,
  input  strb_t  exu_wstrb_i,
  input  wire    exu_wlast_i,
  output logic   exu_wready_o,
  output logic   exu_bvalid_o,
  output resp_t  exu_bresp_o,
  output id_t    exu_bid_o,
  input  wire    exu_bready_i,

  // memory slave.
  output logic   mem_arvalid_o,
  output addr_t  mem_araddr_o,
  output id_t    mem_arid_o,
  output len_t   mem_arlen_o,
  output size_t  mem_arsize_o,
  output burst_t mem_arburst_o,
  input  wire    mem_arready_i,
  input  wire    mem_rvalid_i,
  input  data_t  mem_rdata_i,
  input  resp_t  mem_rresp_i,
  input  id_t    mem_rid_i,
  input  wire    mem_rlast_i,
  output logic   mem_rready_o,
  output logic   mem_awvalid_o,
  output addr_t  mem_awaddr_o,
  output id_t    mem_awid_o,
  output len_t   mem_awlen_o,
  output size_t  mem_awsize_o,
  output burst_t mem_awburst_o,
  input  wire    mem_awready_i,
  output logic   mem_wvalid_o,
  output data_t  mem_wdata_o,
  output strb_t  mem_wstrb_o,
  output logic   mem_wlast_o,
  input  wire    mem_wready_i,
  input  wire    mem_bvalid_i,
  input  resp_t  mem_bresp_i,
  input  id_t    mem_bid_i,
  output logic   mem_bready_o,

  // CLINT slave, read only.
  output logic   clint_arvalid_o,
  output addr_t  clint_araddr_o,
  output id_t    clint_arid_o,
  input  wire    clint_arready_i,
  input  wire    clint_rvalid_i,
  input  data_t  clint_rdata_i,
  input  resp_t  clint_rresp_i,
  input  id_t    clint_rid_i,
  input  wire    clint_rlast_i,
  output logic   clint_rready_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_IFU_RD,
    ST_EXU_RD,
    ST_EXU_WR,
    ST_CLINT_RD
  } grant_t;

  grant_t state_q;
  grant_t state_d;
  logic   in_clint;

  // EXU reads inside the CLINT window go to the timer.
  assign in_clint = (exu_araddr_i >= CLINT_BASE) && (exu_araddr_i <= CLINT_LAST);

  // ##################################################
  // grant state machine.
  // ##################################################
  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // fixed priority: EXU read, EXU write, IFU read.
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (exu_arvalid_i) begin
          state_d = in_clint ? ST_CLINT_RD : ST_EXU_RD;
        end else if (exu_awvalid_i) begin
          state_d = ST_EXU_WR;
        end else if (ifu_arvalid_i) begin
          state_d = ST_IFU_RD;
        end
      end
      ST_IFU_RD: begin
        if (mem_rvalid_i && ifu_rready_i && mem_rlast_i) state_d = ST_IDLE;
      end
      ST_EXU_RD: begin
        if (mem_rvalid_i && exu_rready_i && mem_rlast_i) state_d = ST_IDLE;
      end
      ST_EXU_WR: begin
        if (mem_bvalid_i && exu_bready_i) state_d = ST_IDLE;
      end
      ST_CLINT_RD: begin
        if (clint_rvalid_i && exu_rready_i && clint_rlast_i) state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // ##################################################
  // channel steering.
  // ##################################################
  always_comb begin
    // nothing granted: all valids, readies and payloads low.
    ifu_arready_o   = 1'b0;
    ifu_rvalid_o    = 1'b0;
    ifu_rdata_o     = '0;
    ifu_rresp_o     = '0;
    ifu_rid_o       = '0;
    ifu_rlast_o     = 1'b0;
    exu_arready_o   = 1'b0;
    exu_rvalid_o    = 1'b0;
    exu_rdata_o     = '0;
    exu_rresp_o     = '0;
    exu_rid_o       = '0;
    exu_rlast_o     = 1'b0;
    exu_awready_o   = 1'b0;
    exu_wready_o    = 1'b0;
    exu_bvalid_o    = 1'b0;
    exu_bresp_o     = '0;
    exu_bid_o       = '0;
    mem_arvalid_o   = 1'b0;
    mem_araddr_o    = '0;
    mem_arid_o      = '0;
    mem_arlen_o     = '0;
    mem_arsize_o    = '0;
    mem_arburst_o   = '0;
    mem_rready_o    = 1'b0;
    mem_awvalid_o   = 1'b0;
    mem_awaddr_o    = '0;
    mem_awid_o      = '0;
    mem_awlen_o     = '0;
    mem_awsize_o    = '0;
    mem_awburst_o   = '0;
    mem_wvalid_o    = 1'b0;
    mem_wdata_o     = '0;
    mem_wstrb_o     = '0;
    mem_wlast_o     = 1'b0;
    mem_bready_o    = 1'b0;
    clint_arvalid_o = 1'b0;
    clint_araddr_o  = '0;
    clint_arid_o    = '0;
    clint_rready_o  = 1'b0;
    case (state_q)
      ST_IFU_RD: begin
        mem_arvalid_o = ifu_arvalid_i;
        mem_araddr_o  = ifu_araddr_i;
        mem_arid_o    = ifu_arid_i;
        mem_arlen_o   = ifu_arlen_i;
        mem_arsize_o  = ifu_arsize_i;
        mem_arburst_o = ifu_arburst_i;
        ifu_arready_o = mem_arready_i;
        ifu_rvalid_o  = mem_rvalid_i;
        ifu_rdata_o   = mem_rdata_i;
        ifu_rresp_o   = mem_rresp_i;
        ifu_rid_o     = mem_rid_i;
        ifu_rlast_o   = mem_rlast_i;
        mem_rready_o  = ifu_rready_i;
      end
      ST_EXU_RD: begin
        mem_arvalid_o = exu_arvalid_i;
        mem_araddr_o  = exu_araddr_i;
        mem_arid_o    = exu_arid_i;
        mem_arlen_o   = exu_arlen_i;
        mem_arsize_o  = exu_arsize_i;
        mem_arburst_o = exu_arburst_i;
        exu_arready_o = mem_arready_i;
        exu_rvalid_o  = mem_rvalid_i;
        exu_rdata_o   = mem_rdata_i;
        exu_rresp_o   = mem_rresp_i;
        exu_rid_o     = mem_rid_i;
        exu_rlast_o   = mem_rlast_i;
        mem_rready_o  = exu_rready_i;
      end
      ST_EXU_WR: begin
        mem_awvalid_o = exu_awvalid_i;
        mem_awaddr_o  = exu_awaddr_i;
        mem_awid_o    = exu_awid_i;
        mem_awlen_o   = exu_awlen_i;
        mem_awsize_o  = exu_awsize_i;
        mem_awburst_o = exu_awburst_i;
        exu_awready_o = mem_awready_i;
        mem_wvalid_o  = exu_wvalid_i;
        mem_wdata_o   = exu_wdata_i;
        mem_wstrb_o   = exu_wstrb_i;
        mem_wlast_o   = exu_wlast_i;
        exu_wready_o  = mem_wready_i;
        exu_bvalid_o  = mem_bvalid_i;
        exu_bresp_o   = mem_bresp_i;
        exu_bid_o     = mem_bid_i;
        mem_bready_o  = exu_bready_i;
      end
      ST_CLINT_RD: begin
        clint_arvalid_o = exu_arvalid_i;
        clint_araddr_o  = exu_araddr_i;
        clint_arid_o    = exu_arid_i;
        exu_arready_o   = clint_arready_i;
        exu_rvalid_o    = clint_rvalid_i;
        exu_rdata_o     = clint_rdata_i;
        exu_rresp_o     = clint_rresp_i;
        exu_rid_o       = clint_rid_i;
        exu_rlast_o     = clint_rlast_i;
        clint_rready_o  = exu_rready_i;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/axi_pkg.sv
`default_nettype none

package axi_pkg;

  // ##################################################
  // channel field types.
  // ##################################################
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [3:0]  id_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;
  typedef logic [1:0]  resp_t;

  // response codes.
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ##################################################
  // core-local interruptor address map.
  // ##################################################
  localparam addr_t CLINT_BASE = 32'h0200_0000;
  localparam addr_t CLINT_LAST = 32'h0200_FFFF;

  // offsets inside the CLINT window.
  localparam logic [15:0] MTIME_LO_OFS = 16'hBFF8;
  localparam logic [15:0] MTIME_HI_OFS = 16'hBFFC;

endpackage

`default_nettype wire
